//--- Makefile
VERILATOR ?= verilator
TOP       ?= hydra_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- build.f
+incdir+include
hw/hydra_pkg.sv
hw/port_wr_frontend.sv
hw/bank_allocator.sv
hw/packet_bank.sv
hw/join_arbiter.sv
hw/port_queue.sv
hw/port_rd_frontend.sv
hw/hydra_top.sv
sim/hydra_tb.sv

//--- hw/bank_allocator.sv
`timescale 1ns/1ps
`include "hydra_params.svh"

module bank_allocator (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`HYDRA_PORTS-1:0] start,
    output hydra_pkg::bank_idx_t    grant_bank [`HYDRA_PORTS],
    input  logic [`HYDRA_BANKS-1:0] rel,
    output hydra_pkg::port_idx_t    owner [`HYDRA_BANKS],
    output logic                    full,
    output logic                    almost_full
);
    import hydra_pkg::*;

    logic [`HYDRA_BANKS-1:0]       free_map;
    logic [`HYDRA_BANKS-1:0]       taken;
    logic [`HYDRA_BANKS-1:0]       free_next;
    logic [`HYDRA_PORTS-1:0]       got;
    port_idx_t                     taken_by [`HYDRA_BANKS];
    logic [$clog2(`HYDRA_BANKS):0] free_cnt;

    // lowest free banks handed out in port order
    always_comb begin
        taken = '0;
        got = '0;
        for (int b = 0; b < `HYDRA_BANKS; b++) begin
            taken_by[b] = '0;
        end
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            grant_bank[p] = '0;
            for (int b = 0; b < `HYDRA_BANKS; b++) begin
                if (start[p] && !got[p] && free_map[b] && !taken[b]) begin
                    grant_bank[p] = bank_idx_t'(b);
                    got[p] = 1'b1;
                    taken[b] = 1'b1;
                    taken_by[b] = port_idx_t'(p);
                end
            end
        end
    end

    assign free_next = (free_map & ~taken) | rel;

    always_comb begin
        free_cnt = '0;
        for (int b = 0; b < `HYDRA_BANKS; b++) begin
            free_cnt = free_cnt + free_next[b];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_map <= '1;
            full <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            free_map <= free_next;
            full <= free_cnt == 0;
            almost_full <= free_cnt < `HYDRA_ALMOST_FULL;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < `HYDRA_BANKS; b++) begin
            if (!rst_n) begin
                owner[b] <= '0;
            end else if (taken[b]) begin
                owner[b] <= taken_by[b];
            end
        end
    end

    a_no_bank: assert property (@(posedge clk) disable iff (!rst_n)
        (start & ~got) == '0)
        else $error("packet started with no free bank");

    // a reader only ever frees a bank that was handed out
    a_rel_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (rel & free_map) == '0)
        else $error("release of a bank that is already free");

endmodule

//--- hw/hydra_pkg.sv
`include "hydra_params.svh"

package hydra_pkg;

    typedef logic [`HYDRA_WORD_W-1:0] word_t;
    typedef logic [$clog2(`HYDRA_PORTS)-1:0] port_idx_t;
    typedef logic [$clog2(`HYDRA_PRIORS)-1:0] prior_t;
    typedef logic [$clog2(`HYDRA_BANKS)-1:0] bank_idx_t;

    // word count of a packet, header included; doubles as a bank address
    typedef logic [$clog2(`HYDRA_BANK_DEPTH)-1:0] pkt_len_t;

    typedef struct packed {
        port_idx_t dest;
        prior_t    prior;
        pkt_len_t  len;
        logic [$bits(word_t)-$bits(port_idx_t)-$bits(prior_t)-$bits(pkt_len_t)-1:0] rsvd;
    } pkt_header_t;

    // first word of a packet is read through hdr, every word through raw
    typedef union packed {
        pkt_header_t hdr;
        word_t       raw;
    } pkt_word_u;

    typedef struct packed {
        logic      vld;
        logic      eop;
        pkt_word_u data;
    } wr_xfer_t;

    typedef struct packed {
        logic      vld;
        port_idx_t dest;
        prior_t    prior;
        pkt_len_t  len;
    } join_req_t;

    typedef struct packed {
        bank_idx_t bank;
        pkt_len_t  len;
    } pkt_desc_t;

endpackage

//--- hw/hydra_top.sv
`timescale 1ns/1ps
`include "hydra_params.svh"

module hydra_top (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [`HYDRA_PORTS-1:0]                   wr_sop,
    input  logic [`HYDRA_PORTS-1:0]                   wr_eop,
    input  logic [`HYDRA_PORTS-1:0]                   wr_vld,
    input  logic [`HYDRA_PORTS-1:0][`HYDRA_WORD_W-1:0] wr_data,
    input  logic [`HYDRA_PORTS-1:0]                   ready,
    output logic [`HYDRA_PORTS-1:0]                   rd_sop,
    output logic [`HYDRA_PORTS-1:0]                   rd_eop,
    output logic [`HYDRA_PORTS-1:0]                   rd_vld,
    output logic [`HYDRA_PORTS-1:0][`HYDRA_WORD_W-1:0] rd_data,
    output logic                                      full,
    output logic                                      almost_full
);
    import hydra_pkg::*;

    // ingress side
    logic [`HYDRA_PORTS-1:0] start;
    bank_idx_t               grant_bank [`HYDRA_PORTS];
    wr_xfer_t                wr_xfer [`HYDRA_PORTS];
    bank_idx_t               wr_bank [`HYDRA_PORTS];
    port_idx_t               owner [`HYDRA_BANKS];

    // bank side
    wr_xfer_t                bank_xfer [`HYDRA_BANKS];
    join_req_t               join_req [`HYDRA_BANKS];
    logic [`HYDRA_BANKS-1:0] ack;
    logic [`HYDRA_BANKS-1:0] bank_rd_en;
    logic [`HYDRA_BANKS-1:0] bank_rel;
    pkt_len_t                bank_rd_addr [`HYDRA_BANKS];
    word_t                   bank_word [`HYDRA_BANKS];

    // egress side
    logic [`HYDRA_PORTS-1:0][`HYDRA_PRIORS-1:0] push;
    pkt_desc_t               push_desc;
    pkt_desc_t               q_head [`HYDRA_PORTS];
    logic [`HYDRA_PORTS-1:0] q_not_empty;
    logic [`HYDRA_PORTS-1:0] pop;
    logic [`HYDRA_PORTS-1:0] rd_en;
    logic [`HYDRA_PORTS-1:0] rel;
    bank_idx_t               rd_bank [`HYDRA_PORTS];
    pkt_len_t                rd_addr [`HYDRA_PORTS];
    word_t                   rd_word [`HYDRA_PORTS];

    for (genvar p = 0; p < `HYDRA_PORTS; p++) begin : g_port
        port_wr_frontend u_wr_frontend (
            .clk        (clk),
            .rst_n      (rst_n),
            .sop        (wr_sop[p]),
            .eop        (wr_eop[p]),
            .vld        (wr_vld[p]),
            .data       (wr_data[p]),
            .start      (start[p]),
            .grant_bank (grant_bank[p]),
            .xfer       (wr_xfer[p]),
            .bank       (wr_bank[p])
        );

        port_queue u_port_queue (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push[p]),
            .push_desc (push_desc),
            .pop       (pop[p]),
            .head      (q_head[p]),
            .not_empty (q_not_empty[p])
        );

        port_rd_frontend u_rd_frontend (
            .clk       (clk),
            .rst_n     (rst_n),
            .ready     (ready[p]),
            .not_empty (q_not_empty[p]),
            .head      (q_head[p]),
            .pop       (pop[p]),
            .rd_bank   (rd_bank[p]),
            .rd_addr   (rd_addr[p]),
            .rd_en     (rd_en[p]),
            .rd_word   (rd_word[p]),
            .rel       (rel[p]),
            .rd_sop    (rd_sop[p]),
            .rd_eop    (rd_eop[p]),
            .rd_vld    (rd_vld[p]),
            .rd_data   (rd_data[p])
        );

        // read data comes back from whichever bank this port is draining
        assign rd_word[p] = bank_word[rd_bank[p]];
    end

    for (genvar b = 0; b < `HYDRA_BANKS; b++) begin : g_bank
        // stale owners have moved on to another bank, so check it still points here
        assign bank_xfer[b] = (wr_bank[owner[b]] == bank_idx_t'(b)) ? wr_xfer[owner[b]] : '0;

        packet_bank u_packet_bank (
            .clk      (clk),
            .rst_n    (rst_n),
            .xfer     (bank_xfer[b]),
            .join_req (join_req[b]),
            .ack      (ack[b]),
            .rd_addr  (bank_rd_addr[b]),
            .rd_en    (bank_rd_en[b]),
            .rd_word  (bank_word[b])
        );
    end

    // one reader per bank, so the ports can simply be or-ed in
    always_comb begin
        for (int b = 0; b < `HYDRA_BANKS; b++) begin
            bank_rd_en[b] = 1'b0;
            bank_rd_addr[b] = '0;
            bank_rel[b] = 1'b0;
            for (int p = 0; p < `HYDRA_PORTS; p++) begin
                if (rd_en[p] && rd_bank[p] == bank_idx_t'(b)) begin
                    bank_rd_en[b] = 1'b1;
                    bank_rd_addr[b] = rd_addr[p];
                    bank_rel[b] = rel[p];
                end
            end
        end
    end

    bank_allocator u_bank_allocator (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .grant_bank  (grant_bank),
        .rel         (bank_rel),
        .owner       (owner),
        .full        (full),
        .almost_full (almost_full)
    );

    join_arbiter u_join_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .join_req  (join_req),
        .ack       (ack),
        .push      (push),
        .push_desc (push_desc)
    );

endmodule

//--- hw/join_arbiter.sv
`timescale 1ns/1ps
`include "hydra_params.svh"

module join_arbiter (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  hydra_pkg::join_req_t                       join_req [`HYDRA_BANKS],
    output logic [`HYDRA_BANKS-1:0]                    ack,
    output logic [`HYDRA_PORTS-1:0][`HYDRA_PRIORS-1:0] push,
    output hydra_pkg::pkt_desc_t                       push_desc
);
    import hydra_pkg::*;

    bank_idx_t sel;
    logic      any;

    // lowest pending bank wins
    always_comb begin
        sel = '0;
        any = 1'b0;
        ack = '0;
        for (int b = `HYDRA_BANKS - 1; b >= 0; b--) begin
            if (join_req[b].vld) begin
                sel = bank_idx_t'(b);
                any = 1'b1;
            end
        end
        ack[sel] = any;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push <= '0;
        end else begin
            push <= '0;
            if (any) begin
                push[join_req[sel].dest][join_req[sel].prior] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (any) begin
            push_desc.bank <= sel;
            push_desc.len <= join_req[sel].len;
        end
    end

    // the bank has to drop its request once acked
    a_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
        |ack |=> (ack & $past(ack)) == '0)
        else $error("bank acked twice for one join");

endmodule

//--- hw/packet_bank.sv
`timescale 1ns/1ps
`include "hydra_params.svh"

module packet_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  hydra_pkg::wr_xfer_t   xfer,
    output hydra_pkg::join_req_t  join_req,
    input  logic                  ack,
    input  hydra_pkg::pkt_len_t   rd_addr,
    input  logic                  rd_en,
    output hydra_pkg::word_t      rd_word
);
    import hydra_pkg::*;

    word_t       mem [`HYDRA_BANK_DEPTH];
    pkt_len_t    wr_ptr;
    pkt_header_t hdr;
    logic        pending;

    always_ff @(posedge clk) begin
        if (xfer.vld) begin
            mem[wr_ptr] <= xfer.data.raw;
        end
    end

    // header fields come off word 0
    always_ff @(posedge clk) begin
        if (xfer.vld && wr_ptr == '0) begin
            hdr <= xfer.data.hdr;
        end
    end

    // pointer goes back to 0 at eop, ready for the next owner
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (xfer.vld) begin
            wr_ptr <= xfer.eop ? '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (xfer.vld && xfer.eop) begin
            pending <= 1'b1;
        end else if (ack) begin
            pending <= 1'b0;
        end
    end

    assign join_req.vld = pending;
    assign join_req.dest = hdr.dest;
    assign join_req.prior = hdr.prior;
    assign join_req.len = hdr.len;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

    a_wr_pending: assert property (@(posedge clk) disable iff (!rst_n)
        xfer.vld |-> !pending)
        else $error("write into a bank still waiting to join");

endmodule

//--- hw/port_queue.sv
`timescale 1ns/1ps
`include "hydra_params.svh"

module port_queue (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`HYDRA_PRIORS-1:0] push,
    input  hydra_pkg::pkt_desc_t     push_desc,
    input  logic                     pop,
    output hydra_pkg::pkt_desc_t     head,
    output logic                     not_empty
);
    import hydra_pkg::*;

    localparam int AW = $clog2(`HYDRA_BANKS);

    logic [`HYDRA_PRIORS-1:0] nonempty;
    pkt_desc_t                q_head [`HYDRA_PRIORS];
    prior_t                   pop_prior;

    // strict priority, highest non-empty fifo
    always_comb begin
        pop_prior = '0;
        for (int q = 0; q < `HYDRA_PRIORS; q++) begin
            if (nonempty[q]) begin
                pop_prior = prior_t'(q);
            end
        end
    end

    assign head = q_head[pop_prior];
    assign not_empty = |nonempty;

    for (genvar q = 0; q < `HYDRA_PRIORS; q++) begin : g_fifo
        pkt_desc_t   mem [`HYDRA_BANKS];
        logic [AW:0] wp;
        logic [AW:0] rp;
        logic        do_pop;

        assign do_pop = pop && pop_prior == prior_t'(q);
        assign nonempty[q] = wp != rp;
        assign q_head[q] = mem[rp[AW-1:0]];

        always_ff @(posedge clk) begin
            if (push[q]) begin
                mem[wp[AW-1:0]] <= push_desc;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                wp <= '0;
                rp <= '0;
            end else begin
                if (push[q]) begin
                    wp <= wp + 1'b1;
                end
                if (do_pop) begin
                    rp <= rp + 1'b1;
                end
            end
        end

        a_push_full: assert property (@(posedge clk) disable iff (!rst_n)
            push[q] |-> !(wp[AW] != rp[AW] && wp[AW-1:0] == rp[AW-1:0]))
            else $error("push into a full descriptor fifo");
    end

    a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty)
        else $error("pop from an empty port queue");

endmodule

//--- hw/port_rd_frontend.sv
`timescale 1ns/1ps

module port_rd_frontend (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ready,
    input  logic                 not_empty,
    input  hydra_pkg::pkt_desc_t head,
    output logic                 pop,
    output hydra_pkg::bank_idx_t rd_bank,
    output hydra_pkg::pkt_len_t  rd_addr,
    output logic                 rd_en,
    input  hydra_pkg::word_t     rd_word,
    output logic                 rel,
    output logic                 rd_sop,
    output logic                 rd_eop,
    output logic                 rd_vld,
    output hydra_pkg::word_t     rd_data
);
    import hydra_pkg::*;

    typedef enum logic {
        st_idle,
        st_read
    } state_t;

    state_t   state;
    pkt_len_t cnt;
    pkt_len_t len;
    logic     last;

    // ready only matters between packets
    assign pop = state == st_idle && ready && not_empty;
    assign rd_en = state == st_read;
    assign rd_addr = cnt;
    assign last = cnt == len - 1'b1;
    assign rel = rd_en && last;
    assign rd_data = rd_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else if (pop) begin
            state <= st_read;
        end else if (rel) begin
            state <= st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rd_bank <= head.bank;
            len <= head.len;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cnt <= '0;
        end else if (rd_en) begin
            cnt <= cnt + 1'b1;
        end
    end

    // strobes line up with the bank's one-cycle read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            rd_vld <= rd_en;
            rd_sop <= rd_en && cnt == '0;
            rd_eop <= rel;
        end
    end

endmodule

//--- hw/port_wr_frontend.sv
`timescale 1ns/1ps

module port_wr_frontend (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sop,
    input  logic                 eop,
    input  logic                 vld,
    input  hydra_pkg::pkt_word_u data,
    output logic                 start,
    input  hydra_pkg::bank_idx_t grant_bank,
    output hydra_pkg::wr_xfer_t  xfer,
    output hydra_pkg::bank_idx_t bank
);
    import hydra_pkg::*;

    // words seen so far and words the header promised
    pkt_len_t cnt;
    pkt_len_t exp_len;
    logic     in_pkt;

    // the allocator answers in the same cycle
    assign start = vld && sop;

    always_ff @(posedge clk) begin
        xfer.data <= data;
        if (!rst_n) begin
            xfer.vld <= 1'b0;
            xfer.eop <= 1'b0;
        end else begin
            xfer.vld <= vld;
            xfer.eop <= vld && eop;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank <= '0;
        end else if (start) begin
            bank <= grant_bank;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            exp_len <= data.hdr.len;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
            in_pkt <= 1'b0;
        end else if (vld) begin
            cnt <= sop ? pkt_len_t'(1) : cnt + 1'b1;
            in_pkt <= !eop;
        end
    end

    a_eop_len: assert property (@(posedge clk) disable iff (!rst_n)
        vld && eop |-> (sop ? data.hdr.len == 1 : cnt + 1'b1 == exp_len))
        else $error("eop does not land on the header length");

    a_sop_mid: assert property (@(posedge clk) disable iff (!rst_n)
        vld && sop |-> !in_pkt)
        else $error("sop inside a packet");

endmodule

//--- include/hydra_params.svh
`ifndef HYDRA_PARAMS_SVH
`define HYDRA_PARAMS_SVH

// ingress and egress port count
`define HYDRA_PORTS 4

// storage banks, one packet per bank
`define HYDRA_BANKS 8

// words per bank, also the longest packet
`define HYDRA_BANK_DEPTH 32

// data word width
`define HYDRA_WORD_W 16

// priority levels, 1 is served first
`define HYDRA_PRIORS 2

// almost_full while fewer free banks than this
`define HYDRA_ALMOST_FULL 4

`endif

//--- sim/hydra_tb.sv
`timescale 1ns/1ps
`include "hydra_params.svh"

module hydra_tb;

    localparam int MAX_PKTS = 64;
    localparam int MAX_CMDS = 128;
    localparam int DEPTH = `HYDRA_BANK_DEPTH;

    logic                                      clk;
    logic                                      rst_n;
    logic [`HYDRA_PORTS-1:0]                   wr_sop;
    logic [`HYDRA_PORTS-1:0]                   wr_eop;
    logic [`HYDRA_PORTS-1:0]                   wr_vld;
    logic [`HYDRA_PORTS-1:0][`HYDRA_WORD_W-1:0] wr_data;
    logic [`HYDRA_PORTS-1:0]                   ready;
    logic [`HYDRA_PORTS-1:0]                   rd_sop;
    logic [`HYDRA_PORTS-1:0]                   rd_eop;
    logic [`HYDRA_PORTS-1:0]                   rd_vld;
    logic [`HYDRA_PORTS-1:0][`HYDRA_WORD_W-1:0] rd_data;
    logic                                      full;
    logic                                      almost_full;

    // parsed command lines of kind p h or w
    byte         cmd_kind [MAX_CMDS];
    int          cmd_a [MAX_CMDS];
    int          cmd_b [MAX_CMDS];
    int          n_cmds;

    // one scoreboard entry per sent packet
    int          pkt_src [MAX_PKTS];
    int          pkt_dest [MAX_PKTS];
    int          pkt_prior [MAX_PKTS];
    int          pkt_len [MAX_PKTS];
    int          pkt_gap [MAX_PKTS];
    logic [15:0] pkt_words [MAX_PKTS*DEPTH];
    bit          pkt_held [MAX_PKTS];
    bit          rcvd [MAX_PKTS];
    int          key_map [int];
    int          n_pkts;
    int          rcvd_cnt;

    logic [31:0] lfsr = 32'h7b31_b3b7;
    int          cyc;
    int          hold_until [`HYDRA_PORTS];
    int          wd_limit;
    bit          saw_af;

    // egress monitor state
    bit          in_frame [`HYDRA_PORTS];
    int          wcnt [`HYDRA_PORTS];
    logic [15:0] frame [`HYDRA_PORTS][DEPTH];
    bit          ready_d1 [`HYDRA_PORTS];
    bit          ready_d2 [`HYDRA_PORTS];
    bit          seen_low [`HYDRA_PORTS];
    int          last_seq [`HYDRA_PORTS][`HYDRA_PORTS][`HYDRA_PRIORS];

    hydra_top u_hydra_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .ready       (ready),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data),
        .full        (full),
        .almost_full (almost_full)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %0t %s got %0h expected %0h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic read_tests();
        int    fd;
        int    seq [`HYDRA_PORTS];
        string line;
        logic [63:0] kw;
        int    a, b, c, d, e;
        int    idx;
        logic [15:0] v;
        fd = $fopen("sim/hydra_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/hydra_tests.txt");
            $display("=== FAIL ===");
            $fatal(1);
        end
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            seq[p] = 0;
        end
        n_cmds = 0;
        n_pkts = 0;
        wd_limit = 200;
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            a = 0;
            b = 0;
            c = 0;
            d = 0;
            e = 0;
            void'($sscanf(line, "%s %d %d %d %d %d", kw, a, b, c, d, e));
            cmd_kind[n_cmds] = line.getc(0);
            cmd_a[n_cmds] = a;
            cmd_b[n_cmds] = b;
            if (line.getc(0) == "p") begin
                idx = n_pkts;
                cmd_a[n_cmds] = idx;
                pkt_src[idx] = a;
                pkt_dest[idx] = b;
                pkt_prior[idx] = c;
                pkt_len[idx] = d;
                pkt_gap[idx] = e;
                pkt_words[idx*DEPTH] = {b[1:0], c[0], d[4:0], 8'h00};
                pkt_words[idx*DEPTH+1] = {a[7:0], seq[a][7:0]};
                for (int w = 2; w < d; w++) begin
                    take_bits(16, v);
                    pkt_words[idx*DEPTH+w] = v;
                end
                key_map[a*256 + seq[a]] = idx;
                seq[a]++;
                n_pkts++;
                wd_limit += 64 * d + e;
            end else begin
                wd_limit += (line.getc(0) == "h") ? b : a;
            end
            n_cmds++;
        end
        $fclose(fd);
    endtask

    // inputs move 1 ns after the clock edge
    task automatic tick();
        logic [15:0] v;
        @(posedge clk);
        #1;
        cyc++;
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            if (cyc < hold_until[p]) begin
                ready[p] = 1'b0;
            end else begin
                take_bits(1, v);
                ready[p] = v[0];
            end
        end
    endtask

    task automatic send_packet(input int idx);
        int s;
        s = pkt_src[idx];
        while (almost_full) begin
            tick();
        end
        for (int w = 0; w < pkt_len[idx]; w++) begin
            wr_vld[s] = 1'b1;
            wr_sop[s] = w == 0;
            wr_eop[s] = w == pkt_len[idx] - 1;
            wr_data[s] = pkt_words[idx*DEPTH+w];
            if (w == pkt_len[idx] - 1) begin
                // queued well before the hold lifts
                pkt_held[idx] = hold_until[pkt_dest[idx]] > cyc + 8;
            end
            tick();
        end
        wr_vld[s] = 1'b0;
        wr_sop[s] = 1'b0;
        wr_eop[s] = 1'b0;
        repeat (pkt_gap[idx]) tick();
    endtask

    task automatic finish_frame(input int p);
        int idx;
        int key;
        int src;
        int seq;
        int pr;
        check($sformatf("dest of frame on port %0d", p), frame[p][0][15:14], p);
        check($sformatf("length of frame on port %0d", p), wcnt[p], frame[p][0][12:8]);
        key = frame[p][1][15:8] * 256 + frame[p][1][7:0];
        check($sformatf("known src and seq %0h on port %0d", key, p), key_map.exists(key), 1);
        idx = key_map[key];
        check($sformatf("duplicate packet %0d", idx), rcvd[idx], 0);
        for (int w = 0; w < wcnt[p]; w++) begin
            check($sformatf("packet %0d word %0d", idx, w), frame[p][w],
                  pkt_words[idx*DEPTH+w]);
        end
        src = frame[p][1][15:8];
        seq = frame[p][1][7:0];
        pr = pkt_prior[idx];
        check($sformatf("order of packet %0d", idx), seq > last_seq[src][p][pr], 1);
        last_seq[src][p][pr] = seq;
        if (pkt_held[idx]) begin
            if (pr == 0) begin
                seen_low[p] = 1'b1;
            end else begin
                check($sformatf("held priority 1 packet %0d after priority 0", idx),
                      seen_low[p], 0);
            end
        end
        rcvd[idx] = 1'b1;
        rcvd_cnt++;
    endtask

    task automatic watch_port(input int p);
        if (rd_vld[p]) begin
            if (rd_sop[p]) begin
                check($sformatf("sop inside frame on port %0d", p), in_frame[p], 0);
                check($sformatf("ready before sop on port %0d", p), ready_d2[p], 1);
                in_frame[p] = 1'b1;
                wcnt[p] = 0;
            end else begin
                check($sformatf("vld outside frame on port %0d", p), in_frame[p], 1);
            end
            if (wcnt[p] < DEPTH) begin
                frame[p][wcnt[p]] = rd_data[p];
            end
            wcnt[p]++;
            if (rd_eop[p]) begin
                finish_frame(p);
                in_frame[p] = 1'b0;
            end
        end else begin
            check($sformatf("gap inside frame on port %0d", p), in_frame[p], 0);
            check($sformatf("strobe without vld on port %0d", p), rd_sop[p] | rd_eop[p], 0);
        end
        ready_d2[p] = ready_d1[p];
        ready_d1[p] = ready[p];
    endtask

    // outputs are sampled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (almost_full) begin
                saw_af = 1'b1;
            end
            for (int p = 0; p < `HYDRA_PORTS; p++) begin
                watch_port(p);
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        wr_sop = '0;
        wr_eop = '0;
        wr_vld = '0;
        wr_data = '0;
        ready = '0;
        cyc = 0;
        rcvd_cnt = 0;
        saw_af = 1'b0;
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            hold_until[p] = 0;
            in_frame[p] = 1'b0;
            wcnt[p] = 0;
            ready_d1[p] = 1'b0;
            ready_d2[p] = 1'b0;
            seen_low[p] = 1'b0;
            for (int d = 0; d < `HYDRA_PORTS; d++) begin
                for (int q = 0; q < `HYDRA_PRIORS; q++) begin
                    last_seq[p][d][q] = -1;
                end
            end
        end
        for (int i = 0; i < MAX_PKTS; i++) begin
            rcvd[i] = 1'b0;
            pkt_held[i] = 1'b0;
        end
        read_tests();

        fork
            begin
                repeat (wd_limit) @(posedge clk);
                $display("watchdog expired after %0d cycles, traffic did not drain", wd_limit);
                $display("=== FAIL ===");
                $fatal(1);
            end
        join_none

        repeat (10) tick();
        rst_n = 1'b1;
        tick();
        check("full after reset", full, 0);
        check("almost_full after reset", almost_full, 0);

        for (int i = 0; i < n_cmds; i++) begin
            if (cmd_kind[i] == "p") begin
                send_packet(cmd_a[i]);
            end else if (cmd_kind[i] == "h") begin
                seen_low[cmd_a[i]] = 1'b0;
                hold_until[cmd_a[i]] = cyc + cmd_b[i];
            end else begin
                repeat (cmd_a[i]) tick();
            end
        end

        while (rcvd_cnt < n_pkts) begin
            tick();
        end
        // nothing more may come out
        repeat (40) tick();
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            check($sformatf("frame left open on port %0d", p), in_frame[p], 0);
        end
        check("almost_full seen under the held burst", saw_af, 1);
        check("almost_full after drain", almost_full, 0);
        check("full after drain", full, 0);
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- sim/hydra_tests.txt
# pkt src dest prior len gap | hold port cycles | wait cycles
# len counts the header word, minimum 2
pkt 0 1 0 6 0
pkt 1 2 1 4 2
pkt 2 3 0 10 0
pkt 3 0 1 2 1
pkt 0 1 0 31 0
hold 2 300
pkt 0 2 0 5 0
pkt 1 2 1 6 0
pkt 3 2 0 4 0
pkt 0 2 1 3 0
pkt 2 2 1 7 0
wait 20
pkt 1 0 0 8 3
pkt 2 1 1 12 0
pkt 3 3 0 9 0
